/* design/bg_pkg.sv */
`default_nettype none

package bg_pkg;

	// video memory is 8 KiB addressed from its own base
	localparam int vram_aw = 13;

	// tile maps picked by lcdc_map_sel
	localparam logic [vram_aw-1:0] map_base_0 = 13'h1800;
	localparam logic [vram_aw-1:0] map_base_1 = 13'h1C00;

	// tile data regions picked by lcdc_tile_sel
	localparam logic [vram_aw-1:0] tile_base_unsigned = 13'h0000; // lcdc_tile_sel = 1
	localparam logic [vram_aw-1:0] tile_base_signed   = 13'h1000; // lcdc_tile_sel = 0 with index -128..127

	localparam int line_pixels = 160;

	// 20 visible tiles plus one more for the fine scroll spill
	localparam int line_tiles = 21;
	localparam int line_bits  = line_tiles * 8;

	typedef enum logic [2:0] {
		st_idle,
		st_map_rd,
		st_map_wait,
		st_lo_rd,
		st_lo_wait,
		st_hi_rd,
		st_hi_wait,
		st_hold
	} fetch_state_t;

	// which address the map unit presents
	typedef enum logic [1:0] {
		kind_map,
		kind_lo,
		kind_hi
	} fetch_kind_t;

endpackage

`default_nettype wire

/* design/bg_map_addr.sv */
`timescale 1ns/1ns
`default_nettype none

module bg_map_addr (
	input  logic                         clkpipe,
	input  logic                         rst_n,
	input  logic                         line_start,
	input  logic [7:0]                   ly,
	input  logic [7:0]                   scx,
	input  logic [7:0]                   scy,
	input  logic                         lcdc_map_sel,
	input  logic                         lcdc_tile_sel,
	input  logic                         tile_advance,
	input  bg_pkg::fetch_kind_t          fetch_kind,
	input  logic [7:0]                   tile_idx,
	output logic [bg_pkg::vram_aw-1:0]   vram_addr
);

	logic [7:0] row_q;       // ly + scy wrapping at 256
	logic [4:0] coarse_q;    // scx / 8
	logic       map_sel_q;
	logic       tile_sel_q;
	logic [4:0] tile_col;

	logic [4:0]                 col;
	logic [9:0]                 map_off;
	logic [bg_pkg::vram_aw-1:0] map_addr;
	logic [bg_pkg::vram_aw-1:0] data_base;
	logic [bg_pkg::vram_aw-1:0] lo_addr;

	always_ff @(posedge clkpipe) begin
		if (!rst_n) begin
			row_q      <= '0;
			coarse_q   <= '0;
			map_sel_q  <= 1'b0;
			tile_sel_q <= 1'b0;
			tile_col   <= '0;
		end else if (line_start) begin
			row_q      <= ly + scy;
			coarse_q   <= scx[7:3];
			map_sel_q  <= lcdc_map_sel;
			tile_sel_q <= lcdc_tile_sel;
			tile_col   <= '0;
		end else if (tile_advance) begin
			tile_col <= tile_col + 5'd1; // wraps at 32
		end
	end

	assign col     = coarse_q + tile_col; // horizontal wrap inside the 32 wide map
	assign map_off = {row_q[7:3], col};
	assign map_addr = (map_sel_q ? bg_pkg::map_base_1 : bg_pkg::map_base_0) + {3'b000, map_off};

	// signed mode sign-extends the index before scaling by 16
	assign data_base = tile_sel_q ?
		bg_pkg::tile_base_unsigned + {1'b0, tile_idx, 4'b0000} :
		bg_pkg::tile_base_signed + {tile_idx[7], tile_idx, 4'b0000};

	assign lo_addr = data_base + {9'd0, row_q[2:0], 1'b0}; // two bytes per tile row

	always_comb begin
		case (fetch_kind)
			bg_pkg::kind_map: vram_addr = map_addr;
			bg_pkg::kind_lo:  vram_addr = lo_addr;
			default:          vram_addr = lo_addr + 13'd1; // high plane follows low
		endcase
	end

endmodule

`default_nettype wire

/* design/bg_fetcher.sv */
`timescale 1ns/1ns
`default_nettype none

module bg_fetcher (
	input  logic                clkpipe,
	input  logic                rst_n,
	input  logic                line_start,
	input  logic                line_done,
	input  logic                vram_req_ready,
	input  logic [7:0]          vram_rdata,
	input  logic                vram_rdata_valid,
	input  logic                plane_empty,
	output logic                vram_req_valid,
	output bg_pkg::fetch_kind_t fetch_kind,
	output logic                tile_advance,
	output logic [7:0]          tile_idx,
	output logic [7:0]          tile_lo,
	output logic [7:0]          tile_hi,
	output logic                plane_load,
	output logic                line_busy
);

	bg_pkg::fetch_state_t state;
	bg_pkg::fetch_state_t state_nx;

	logic [4:0] tile_cnt; // tiles handed to the shifters this line
	logic       last_tile;

	assign last_tile = tile_cnt == 5'(bg_pkg::line_tiles - 1);

	always_comb begin
		state_nx       = state;
		vram_req_valid = 1'b0;
		fetch_kind     = bg_pkg::kind_map;
		tile_advance   = 1'b0;
		plane_load     = 1'b0;

		case (state)
			bg_pkg::st_idle: begin
				if (line_start)
					state_nx = bg_pkg::st_map_rd;
			end
			bg_pkg::st_map_rd: begin
				vram_req_valid = 1'b1;
				if (vram_req_ready)
					state_nx = bg_pkg::st_map_wait;
			end
			bg_pkg::st_map_wait: begin
				if (vram_rdata_valid) begin
					tile_advance = 1'b1; // next map column for the following tile
					state_nx     = bg_pkg::st_lo_rd;
				end
			end
			bg_pkg::st_lo_rd: begin
				vram_req_valid = 1'b1;
				fetch_kind     = bg_pkg::kind_lo;
				if (vram_req_ready)
					state_nx = bg_pkg::st_lo_wait;
			end
			bg_pkg::st_lo_wait: begin
				if (vram_rdata_valid)
					state_nx = bg_pkg::st_hi_rd;
			end
			bg_pkg::st_hi_rd: begin
				vram_req_valid = 1'b1;
				fetch_kind     = bg_pkg::kind_hi;
				if (vram_req_ready)
					state_nx = bg_pkg::st_hi_wait;
			end
			bg_pkg::st_hi_wait: begin
				if (vram_rdata_valid)
					state_nx = bg_pkg::st_hold;
			end
			bg_pkg::st_hold: begin
				// byte pair waits here until the shifters run dry
				if (plane_empty) begin
					plane_load = 1'b1;
					state_nx   = last_tile ? bg_pkg::st_idle : bg_pkg::st_map_rd;
				end
			end
			default: state_nx = bg_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clkpipe) begin
		if (!rst_n) begin
			state     <= bg_pkg::st_idle;
			line_busy <= 1'b0;
			tile_cnt  <= '0;
		end else begin
			state <= line_done ? bg_pkg::st_idle : state_nx;

			if (line_start)
				line_busy <= 1'b1;
			else if (line_done)
				line_busy <= 1'b0;

			if (line_start)
				tile_cnt <= '0;
			else if (plane_load)
				tile_cnt <= tile_cnt + 5'd1;
		end
	end

	// response bytes
	always_ff @(posedge clkpipe) begin
		if (vram_rdata_valid) begin
			case (state)
				bg_pkg::st_map_wait: tile_idx <= vram_rdata;
				bg_pkg::st_lo_wait:  tile_lo  <= vram_rdata;
				bg_pkg::st_hi_wait:  tile_hi  <= vram_rdata;
				default: ;
			endcase
		end
	end

	// memory side must answer exactly one cycle after an accepted request
	a_rsp_follows_req: assert property (@(posedge clkpipe) disable iff (!rst_n)
		vram_rdata_valid |-> $past(vram_req_valid && vram_req_ready));

	a_load_in_line: assert property (@(posedge clkpipe) disable iff (!rst_n)
		plane_load |-> line_busy);

endmodule

`default_nettype wire

/* design/bg_plane_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

module bg_plane_shifter (
	input  logic       clkpipe,
	input  logic       rst_n,
	input  logic       load,
	input  logic       shift,
	input  logic [7:0] data,
	output logic       bit_out,
	output logic       empty
);

	logic [7:0] data_q;
	logic [3:0] cnt; // bits still held from 0 to 8

	always_ff @(posedge clkpipe) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= 4'd8;
		end else if (shift) begin
			cnt <= cnt - 4'd1;
		end
	end

	always_ff @(posedge clkpipe) begin
		if (load)
			data_q <= data;
		else if (shift)
			data_q <= {data_q[6:0], 1'b0}; // msb leaves first
	end

	assign bit_out = data_q[7];
	assign empty   = cnt == 4'd0;

	// fetcher only refills a drained plane
	a_load_when_empty: assert property (@(posedge clkpipe) disable iff (!rst_n)
		load |-> empty);

	// and the mixer never pulls from an empty one
	a_shift_when_full: assert property (@(posedge clkpipe) disable iff (!rst_n)
		shift |-> !empty);

endmodule

`default_nettype wire

/* design/bg_pixel_mixer.sv */
`timescale 1ns/1ns
`default_nettype none

module bg_pixel_mixer (
	input  logic       clkpipe,
	input  logic       rst_n,
	input  logic       line_start,
	input  logic [7:0] scx,
	input  logic       bit_lo,
	input  logic       bit_hi,
	input  logic       plane_empty,
	input  logic [7:0] bgp,
	input  logic       pix_ready,
	output logic       shift,
	output logic [1:0] pix_shade,
	output logic       pix_valid,
	output logic       line_done
);

	logic       active_q;
	logic [2:0] fine_q;
	logic [7:0] bit_cnt; // every bit shifted this line including discards
	logic [7:0] pix_cnt; // pixels handed out

	logic       discard;
	logic       pix_phase;
	logic       drain;
	logic       out_free;
	logic       take;
	logic [1:0] cidx;

	assign discard   = bit_cnt < {5'd0, fine_q};
	assign pix_phase = !discard && (bit_cnt < 8'(bg_pkg::line_pixels) + {5'd0, fine_q});
	assign drain     = !discard && !pix_phase && (bit_cnt != 8'(bg_pkg::line_bits)); // spare bits of the last tile

	assign out_free = !pix_valid || pix_ready;
	assign shift    = active_q && !plane_empty && (discard || drain || (pix_phase && out_free));
	assign take     = shift && pix_phase;

	assign cidx = {bit_hi, bit_lo};

	always_ff @(posedge clkpipe) begin
		if (!rst_n) begin
			active_q  <= 1'b0;
			fine_q    <= '0;
			bit_cnt   <= '0;
			pix_cnt   <= '0;
			pix_valid <= 1'b0;
			line_done <= 1'b0;
		end else begin
			line_done <= 1'b0;
			if (line_start) begin
				active_q <= 1'b1;
				fine_q   <= scx[2:0];
				bit_cnt  <= '0;
				pix_cnt  <= '0;
			end else begin
				if (shift)
					bit_cnt <= bit_cnt + 8'd1;
				if (pix_valid && pix_ready)
					pix_cnt <= pix_cnt + 8'd1;
				// all pixels out and the planes drained
				if (active_q && pix_cnt == 8'(bg_pkg::line_pixels) &&
						bit_cnt == 8'(bg_pkg::line_bits)) begin
					line_done <= 1'b1;
					active_q  <= 1'b0;
				end
			end

			if (take)
				pix_valid <= 1'b1;
			else if (pix_ready)
				pix_valid <= 1'b0;
		end
	end

	always_ff @(posedge clkpipe) begin
		if (take)
			pix_shade <= bgp[{cidx, 1'b0} +: 2]; // palette bits 2c+1:2c
	end

endmodule

`default_nettype wire

/* design/bg_top.sv */
`timescale 1ns/1ns
`default_nettype none

module bg_top (
	input  logic                       clkpipe,
	input  logic                       rst_n,
	input  logic                       line_start,
	input  logic [7:0]                 ly,
	input  logic [7:0]                 scx,
	input  logic [7:0]                 scy,
	input  logic                       lcdc_map_sel,
	input  logic                       lcdc_tile_sel,
	input  logic [7:0]                 bgp,
	output logic [bg_pkg::vram_aw-1:0] vram_addr,
	output logic                       vram_req_valid,
	input  logic                       vram_req_ready,
	input  logic [7:0]                 vram_rdata,
	input  logic                       vram_rdata_valid,
	output logic [1:0]                 pix_shade,
	output logic                       pix_valid,
	input  logic                       pix_ready,
	output logic                       line_done,
	output logic                       line_busy
);

	logic                line_go; // accepted line command
	bg_pkg::fetch_kind_t fetch_kind;
	logic                tile_advance;
	logic [7:0]          tile_idx;
	logic [7:0]          tile_lo;
	logic [7:0]          tile_hi;
	logic                plane_load;
	logic                plane_empty;
	logic                shift;
	logic [7:0]          plane_byte [2];
	logic [1:0]          plane_bit;

	assign line_go = line_start && !line_busy;

	bg_map_addr u_map_addr (
		.clkpipe       (clkpipe),
		.rst_n         (rst_n),
		.line_start    (line_go),
		.ly            (ly),
		.scx           (scx),
		.scy           (scy),
		.lcdc_map_sel  (lcdc_map_sel),
		.lcdc_tile_sel (lcdc_tile_sel),
		.tile_advance  (tile_advance),
		.fetch_kind    (fetch_kind),
		.tile_idx      (tile_idx),
		.vram_addr     (vram_addr)
	);

	bg_fetcher u_fetcher (
		.clkpipe          (clkpipe),
		.rst_n            (rst_n),
		.line_start       (line_go),
		.line_done        (line_done),
		.vram_req_ready   (vram_req_ready),
		.vram_rdata       (vram_rdata),
		.vram_rdata_valid (vram_rdata_valid),
		.plane_empty      (plane_empty),
		.vram_req_valid   (vram_req_valid),
		.fetch_kind       (fetch_kind),
		.tile_advance     (tile_advance),
		.tile_idx         (tile_idx),
		.tile_lo          (tile_lo),
		.tile_hi          (tile_hi),
		.plane_load       (plane_load),
		.line_busy        (line_busy)
	);

	assign plane_byte[0] = tile_lo;
	assign plane_byte[1] = tile_hi;

	// both planes load and shift together, so plane 0 speaks for the pair
	for (genvar plane = 0; plane < 2; plane++) begin : g_plane
		if (plane == 0) begin : g_lead
			bg_plane_shifter u_shifter (
				.clkpipe (clkpipe),
				.rst_n   (rst_n),
				.load    (plane_load),
				.shift   (shift),
				.data    (plane_byte[plane]),
				.bit_out (plane_bit[plane]),
				.empty   (plane_empty)
			);
		end else begin : g_follow
			bg_plane_shifter u_shifter (
				.clkpipe (clkpipe),
				.rst_n   (rst_n),
				.load    (plane_load),
				.shift   (shift),
				.data    (plane_byte[plane]),
				.bit_out (plane_bit[plane]),
				.empty   ()
			);
		end
	end

	bg_pixel_mixer u_mixer (
		.clkpipe     (clkpipe),
		.rst_n       (rst_n),
		.line_start  (line_go),
		.scx         (scx),
		.bit_lo      (plane_bit[0]),
		.bit_hi      (plane_bit[1]),
		.plane_empty (plane_empty),
		.bgp         (bgp),
		.pix_ready   (pix_ready),
		.shift       (shift),
		.pix_shade   (pix_shade),
		.pix_valid   (pix_valid),
		.line_done   (line_done)
	);

endmodule

`default_nettype wire

/* sim/bg_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module bg_tb;

	localparam int max_line_cycles = 2000; // budget per test record

	logic                       clkpipe = 1'b0;
	logic                       rst_n;
	logic                       line_start;
	logic [7:0]                 ly;
	logic [7:0]                 scx;
	logic [7:0]                 scy;
	logic                       lcdc_map_sel;
	logic                       lcdc_tile_sel;
	logic [7:0]                 bgp;
	logic [bg_pkg::vram_aw-1:0] vram_addr;
	logic                       vram_req_valid;
	logic                       vram_req_ready = 1'b0;
	logic [7:0]                 vram_rdata = 8'h00;
	logic                       vram_rdata_valid = 1'b0;
	logic [1:0]                 pix_shade;
	logic                       pix_valid;
	logic                       pix_ready = 1'b0;
	logic                       line_done;
	logic                       line_busy;

	logic [7:0]                 mem [8192];
	logic [31:0]                rng = 32'hf955fed0;
	logic                       req_taken = 1'b0;
	logic [bg_pkg::vram_aw-1:0] req_addr = '0;
	logic                       req_pending = 1'b0;
	logic [bg_pkg::vram_aw-1:0] held_addr = '0;
	logic                       hold_pending = 1'b0;
	logic [1:0]                 held_shade = 2'b00;
	int                         cycles = 0;
	int                         cycle_limit = 0;
	int                         done_total = 0;
	int                         got_q [$]; // every transferred shade over all lines
	string                      cur_name = "reset";

	string t_name [$];
	int    t_ly [$];
	int    t_scx [$];
	int    t_scy [$];
	int    t_msel [$];
	int    t_tsel [$];
	int    t_bgp [$];
	int    t_e0 [$];
	int    t_e80 [$];

	bg_top UUT (
		.clkpipe          (clkpipe),
		.rst_n            (rst_n),
		.line_start       (line_start),
		.ly               (ly),
		.scx              (scx),
		.scy              (scy),
		.lcdc_map_sel     (lcdc_map_sel),
		.lcdc_tile_sel    (lcdc_tile_sel),
		.bgp              (bgp),
		.vram_addr        (vram_addr),
		.vram_req_valid   (vram_req_valid),
		.vram_req_ready   (vram_req_ready),
		.vram_rdata       (vram_rdata),
		.vram_rdata_valid (vram_rdata_valid),
		.pix_shade        (pix_shade),
		.pix_valid        (pix_valid),
		.pix_ready        (pix_ready),
		.line_done        (line_done),
		.line_busy        (line_busy)
	);

	always #50 clkpipe = ~clkpipe;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input int exp, input int act);
		if (exp != act)
			fail_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic tick();
		@(posedge clkpipe);
		#5;
	endtask

	// shade of pixel p of test t from the scroll, map and palette rules
	function automatic int model_shade(input int p, input int t);
		int row;
		int col;
		int bitpos;
		int map_a;
		int idx;
		int data_a;
		int c;
		row    = (t_ly[t] + t_scy[t]) % 256;
		col    = (t_scx[t] / 8 + (t_scx[t] % 8 + p) / 8) % 32;
		bitpos = (t_scx[t] % 8 + p) % 8;
		map_a  = t_msel[t] != 0 ? int'(bg_pkg::map_base_1) : int'(bg_pkg::map_base_0);
		map_a  = map_a + 32 * (row / 8) + col;
		idx    = int'(mem[13'(map_a)]);
		if (t_tsel[t] != 0)
			data_a = int'(bg_pkg::tile_base_unsigned) + 16 * idx;
		else if (idx > 127)
			data_a = int'(bg_pkg::tile_base_signed) + 16 * (idx - 256);
		else
			data_a = int'(bg_pkg::tile_base_signed) + 16 * idx;
		data_a = data_a + 2 * (row % 8);
		c = 2 * ((int'(mem[13'(data_a + 1)]) >> (7 - bitpos)) & 1);
		c = c + ((int'(mem[13'(data_a)]) >> (7 - bitpos)) & 1);
		return (t_bgp[t] >> (2 * c)) & 3;
	endfunction

	task automatic parse_record(input string line);
		int    n;
		int    v [8];
		string name;
		if (line.getc(0) == "w") begin
			n = $sscanf(line, "w %h %h", v[0], v[1]);
			if (n != 2)
				fail_run({"unreadable memory record: ", line});
			else
				mem[13'(v[0])] = 8'(v[1]);
		end else if (line.getc(0) == "t") begin
			n = $sscanf(line, "t %s %h %h %h %h %h %h %h %h", name,
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
			if (n != 9) begin
				fail_run({"unreadable test record: ", line});
			end else begin
				t_name.push_back(name);
				t_ly.push_back(v[0]);
				t_scx.push_back(v[1]);
				t_scy.push_back(v[2]);
				t_msel.push_back(v[3]);
				t_tsel.push_back(v[4]);
				t_bgp.push_back(v[5]);
				t_e0.push_back(v[6]);
				t_e80.push_back(v[7]);
			end
		end else begin
			fail_run({"unknown record kind in stimulus file: ", line});
		end
	endtask

	task automatic load_stimulus();
		int    fd;
		int    n;
		string line;
		fd = $fopen("sim/bg_stimulus.txt", "r");
		if (fd == 0) begin
			fail_run("could not open sim/bg_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#")
					parse_record(line);
			end
			$fclose(fd);
			if (t_name.size() == 0)
				fail_run("the stimulus file holds no test records");
		end
	endtask

	// memory answers one cycle after an accepted request
	// both ready lines toggle at random
	always @(posedge clkpipe) begin
		#5;
		vram_rdata_valid = rst_n && req_taken;
		vram_rdata       = mem[req_addr];
		rng              = lcg_next(rng);
		vram_req_ready   = rng[31:30] != 2'b00;
		pix_ready        = rng[29:28] != 2'b00;
	end

	// mid-cycle sampling where DUT outputs and tb drives have settled
	always @(negedge clkpipe) begin
		req_taken = vram_req_valid && vram_req_ready;
		req_addr  = vram_addr;
		if (rst_n) begin
			if (req_pending) begin
				check({cur_name, " request held valid"}, 1, int'(vram_req_valid));
				check({cur_name, " request held address"}, int'(held_addr), int'(vram_addr));
			end
			req_pending = vram_req_valid && !vram_req_ready;
			held_addr   = vram_addr;
			if (hold_pending) begin
				check({cur_name, " pixel held valid"}, 1, int'(pix_valid));
				check({cur_name, " pixel held shade"}, int'(held_shade), int'(pix_shade));
			end
			hold_pending = pix_valid && !pix_ready;
			held_shade   = pix_shade;
			if (pix_valid && pix_ready)
				got_q.push_back(int'(pix_shade));
			if (line_done)
				done_total++;
		end
		cycles++;
		if (cycles > cycle_limit)
			fail_run($sformatf("the run timed out after %0d cycles", cycles));
	end

	task automatic run_line(input int k);
		int exp_shade [bg_pkg::line_pixels];
		int pix_base;
		int done_base;
		cur_name  = t_name[k];
		pix_base  = got_q.size();
		done_base = done_total;
		for (int i = 0; i < bg_pkg::line_pixels; i++)
			exp_shade[i] = model_shade(i, k);
		check({cur_name, " file pixel 0"}, t_e0[k], exp_shade[0]);
		check({cur_name, " file pixel 80"}, t_e80[k], exp_shade[80]);

		ly            = 8'(t_ly[k]);
		scx           = 8'(t_scx[k]);
		scy           = 8'(t_scy[k]);
		lcdc_map_sel  = t_msel[k] != 0;
		lcdc_tile_sel = t_tsel[k] != 0;
		bgp           = 8'(t_bgp[k]);
		line_start    = 1'b1;
		tick();
		line_start = 1'b0;
		check({cur_name, " busy after start"}, 1, int'(line_busy));

		while (done_total == done_base)
			tick();
		repeat (2) tick(); // a late pixel or a second pulse would show up here
		check({cur_name, " line_done pulses"}, 1, done_total - done_base);
		check({cur_name, " busy after line"}, 0, int'(line_busy));
		check({cur_name, " pixel count"}, bg_pkg::line_pixels, got_q.size() - pix_base);
		for (int i = 0; i < bg_pkg::line_pixels; i++)
			check($sformatf("%s pixel %0d", cur_name, i), exp_shade[i], got_q[pix_base + i]);
	endtask

	initial begin
		rst_n         = 1'b0;
		line_start    = 1'b0;
		ly            = 8'h00;
		scx           = 8'h00;
		scy           = 8'h00;
		lcdc_map_sel  = 1'b0;
		lcdc_tile_sel = 1'b0;
		bgp           = 8'hE4;
		for (int a = 0; a < 8192; a++)
			mem[13'(a)] = 8'(a) ^ 8'((a >> 8) * 53);
		load_stimulus();
		cycle_limit = t_name.size() * max_line_cycles;

		repeat (5) tick();
		check("reset outputs", 0, int'({vram_req_valid, pix_valid, line_done, line_busy}));
		rst_n = 1'b1;

		for (int k = 0; k < t_name.size(); k++)
			run_line(k);

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/bg_stimulus.txt */
# w <addr> <byte>                  video memory preload, hex
# t <name> <ly> <scx> <scy> <map_sel> <tile_sel> <bgp> <shade px0> <shade px80>, hex
w 1800 01
w 180A 02
w 0010 80
w 0011 00
w 0020 80
w 0021 80
w 181E 03
w 1808 04
w 0030 00
w 0031 10
w 0040 10
w 0041 00
w 1840 05
w 184A 06
w 0054 00
w 0055 80
w 0064 80
w 0065 00
w 1C40 07
w 1C4A 05
w 0074 80
w 0075 80
w 1C00 80
w 1C0A 03
w 0800 80
w 0801 00
w 1030 00
w 1031 80
t plain 00 00 00 0 1 E4 1 3
t scroll_x 00 F3 00 0 1 E4 2 1
t scroll_y_map0 30 00 E2 0 1 E4 2 1
t scroll_y_map1 30 00 E2 1 1 E4 3 2
t signed_tiles 00 00 00 1 0 E4 1 2
t palette_inv 00 00 00 0 1 1B 2 0
t palette_dim 00 00 00 0 1 90 0 2

/* all.f */
design/bg_pkg.sv
design/bg_map_addr.sv
design/bg_fetcher.sv
design/bg_plane_shifter.sv
design/bg_pixel_mixer.sv
design/bg_top.sv
sim/bg_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build bg_tb with Verilator, run it and look for the pass message"
	@echo "  clean  remove the Verilator build folder"

obj_dir/Vbg_tb: all.f $(wildcard design/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module bg_tb -f all.f -o Vbg_tb

test: obj_dir/Vbg_tb sim/bg_stimulus.txt
	@out="$$(./obj_dir/Vbg_tb 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
